/* Bender.yml */
package:
  name: pipe_ctrl

sources:
  - pipe_ctrl_pkg.sv
  - instr_decoder.sv
  - stall_ctrl.sv
  - cw_pipe.sv
  - pipe_ctrl_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pipe_ctrl.sv

/* cw_pipe.sv */
// control word stage registers
`timescale 1ns/100ps

module cw_pipe (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 i_fetch_rdy,
    input  logic                                 i_br_en,
    input  logic [pipe_ctrl_pkg::NUM_STAGES-1:0] i_stage_ld,
    input  logic [pipe_ctrl_pkg::NUM_STAGES-1:0] i_stage_rdy,
    input  pipe_ctrl_pkg::alu_op_t               i_alu_op,
    input  pipe_ctrl_pkg::alu_src1_t             i_alu_src1,
    input  pipe_ctrl_pkg::alu_src2_t             i_alu_src2,
    input  pipe_ctrl_pkg::cmp_op_t               i_cmp_op,
    input  pipe_ctrl_pkg::cmp_src_t              i_cmp_src,
    input  logic                                 i_mem_read,
    input  logic                                 i_mem_write,
    input  logic                                 i_ld_reg,
    input  pipe_ctrl_pkg::wb_src_t               i_wb_src,
    input  logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] i_rd,
    input  pipe_ctrl_pkg::opcode_t               i_opcode,
    output logic [pipe_ctrl_pkg::NUM_STAGES-1:0] o_stage_valid,
    output pipe_ctrl_pkg::alu_op_t               o_alu_op,
    output pipe_ctrl_pkg::alu_src1_t             o_alu_src1,
    output pipe_ctrl_pkg::alu_src2_t             o_alu_src2,
    output pipe_ctrl_pkg::cmp_op_t               o_cmp_op,
    output pipe_ctrl_pkg::cmp_src_t              o_cmp_src,
    output pipe_ctrl_pkg::pc_src_t               o_pc_src,
    output logic                                 o_mem_read,
    output logic                                 o_mem_write,
    output logic                                 o_ld_reg,
    output pipe_ctrl_pkg::wb_src_t               o_wb_src,
    output logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] o_rd
);
    import pipe_ctrl_pkg::*;

    // stage index: 0 de, 1 exe, 2 mem, 3 wb
    logic [NUM_STAGES-1:0] stage_valid;
    logic [NUM_STAGES-1:0] stall;

    // d_ decode, x_ execute, m_ memory, w_ writeback
    alu_op_t               d_alu_op,   x_alu_op;
    alu_src1_t             d_alu_src1, x_alu_src1;
    alu_src2_t             d_alu_src2, x_alu_src2;
    cmp_op_t               d_cmp_op,   x_cmp_op;
    cmp_src_t              d_cmp_src,  x_cmp_src;
    opcode_t               d_opcode,   x_opcode;
    logic                  d_mem_read, x_mem_read, m_mem_read;
    logic                  d_mem_write, x_mem_write, m_mem_write;
    logic                  d_ld_reg, x_ld_reg, m_ld_reg, w_ld_reg;
    wb_src_t               d_wb_src, x_wb_src, m_wb_src, w_wb_src;
    logic [REG_ADDR_W-1:0] d_rd, x_rd, m_rd, w_rd;

    assign stall = stage_valid & ~i_stage_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= '0;
        end else begin
            if (i_stage_ld[0]) begin
                stage_valid[0] <= i_fetch_rdy;
            end
            // a stalled source leaves a bubble behind a draining stage
            for (int k = 1; k < NUM_STAGES; k++) begin
                if (i_stage_ld[k]) begin
                    stage_valid[k] <= stage_valid[k-1] & ~stall[k-1];
                end
            end
        end
    end

    // side effect flags go to zero along with valid in a bubble
    always_ff @(posedge clk) begin
        if (i_stage_ld[0]) begin
            d_alu_op    <= i_alu_op;
            d_alu_src1  <= i_alu_src1;
            d_alu_src2  <= i_alu_src2;
            d_cmp_op    <= i_cmp_op;
            d_cmp_src   <= i_cmp_src;
            d_opcode    <= i_opcode;
            d_mem_read  <= i_mem_read & i_fetch_rdy;
            d_mem_write <= i_mem_write & i_fetch_rdy;
            d_ld_reg    <= i_ld_reg & i_fetch_rdy;
            d_wb_src    <= i_wb_src;
            d_rd        <= i_rd;
        end
        if (i_stage_ld[1]) begin
            x_alu_op    <= d_alu_op;
            x_alu_src1  <= d_alu_src1;
            x_alu_src2  <= d_alu_src2;
            x_cmp_op    <= d_cmp_op;
            x_cmp_src   <= d_cmp_src;
            x_opcode    <= d_opcode;
            x_mem_read  <= d_mem_read & ~stall[0];
            x_mem_write <= d_mem_write & ~stall[0];
            x_ld_reg    <= d_ld_reg & ~stall[0];
            x_wb_src    <= d_wb_src;
            x_rd        <= d_rd;
        end
        if (i_stage_ld[2]) begin
            m_mem_read  <= x_mem_read & ~stall[1];
            m_mem_write <= x_mem_write & ~stall[1];
            m_ld_reg    <= x_ld_reg & ~stall[1];
            m_wb_src    <= x_wb_src;
            m_rd        <= x_rd;
        end
        if (i_stage_ld[3]) begin
            w_ld_reg <= m_ld_reg & ~stall[2];
            w_wb_src <= m_wb_src;
            w_rd     <= m_rd;
        end
    end

    // next pc from the word in execute
    always_comb begin
        o_pc_src = pc_plus4;
        if (stage_valid[1]) begin
            case (x_opcode)
                op_jal:  o_pc_src = pc_alu;
                op_jalr: o_pc_src = pc_alu_mod2;
                op_br:   o_pc_src = i_br_en ? pc_alu : pc_plus4;
                default: ;
            endcase
        end
    end

    assign o_stage_valid = stage_valid;
    assign o_alu_op      = x_alu_op;
    assign o_alu_src1    = x_alu_src1;
    assign o_alu_src2    = x_alu_src2;
    assign o_cmp_op      = x_cmp_op;
    assign o_cmp_src     = x_cmp_src;
    // flags only count while their own stage is live
    assign o_mem_read    = stage_valid[2] & m_mem_read;
    assign o_mem_write   = stage_valid[2] & m_mem_write;
    assign o_ld_reg      = stage_valid[3] & w_ld_reg;
    assign o_wb_src      = w_wb_src;
    assign o_rd          = w_rd;

endmodule

/* flist.f */
+incdir+.
pipe_ctrl_pkg.sv
instr_decoder.sv
stall_ctrl.sv
cw_pipe.sv
pipe_ctrl_top.sv
tb_pipe_ctrl.sv

/* instr_decoder.sv */
// rv32i control field decoder
`timescale 1ns/100ps

module instr_decoder (
    input  logic [pipe_ctrl_pkg::INSTR_W-1:0]    i_instr,
    output pipe_ctrl_pkg::alu_op_t               o_alu_op,
    output pipe_ctrl_pkg::alu_src1_t             o_alu_src1,
    output pipe_ctrl_pkg::alu_src2_t             o_alu_src2,
    output pipe_ctrl_pkg::cmp_op_t               o_cmp_op,
    output pipe_ctrl_pkg::cmp_src_t              o_cmp_src,
    output logic                                 o_mem_read,
    output logic                                 o_mem_write,
    output logic                                 o_ld_reg,
    output pipe_ctrl_pkg::wb_src_t               o_wb_src,
    output logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] o_rd,
    output pipe_ctrl_pkg::opcode_t               o_opcode
);
    import pipe_ctrl_pkg::*;

    logic [2:0] funct3;
    // funct7[5] picks sub and sra
    logic       funct7_b5;

    assign o_opcode  = opcode_t'(i_instr[6:0]);
    assign o_rd      = i_instr[11:7];
    assign funct3    = i_instr[14:12];
    assign funct7_b5 = i_instr[30];

    always_comb begin
        // defaults, rs1 + i_imm with no side effects
        o_alu_op    = alu_add;
        o_alu_src1  = src1_rs1;
        o_alu_src2  = src2_i_imm;
        o_cmp_op    = beq;
        o_cmp_src   = cmp_rs2;
        o_mem_read  = 1'b0;
        o_mem_write = 1'b0;
        o_ld_reg    = 1'b0;
        o_wb_src    = wb_alu;

        case (o_opcode)
            op_lui: begin
                o_ld_reg = 1'b1;
                o_wb_src = wb_u_imm;
            end
            op_auipc: begin
                o_alu_src1 = src1_pc;
                o_alu_src2 = src2_u_imm;
                o_ld_reg   = 1'b1;
            end
            op_jal: begin
                o_alu_src1 = src1_pc;
                o_alu_src2 = src2_j_imm;
                o_ld_reg   = 1'b1;
                o_wb_src   = wb_pc_plus4;
            end
            // target is rs1 + i_imm, the default
            op_jalr: begin
                o_ld_reg = 1'b1;
                o_wb_src = wb_pc_plus4;
            end
            op_br: begin
                // alu always builds pc + b_imm, br_en decides later
                o_alu_src1 = src1_pc;
                o_alu_src2 = src2_b_imm;
                case (funct3)
                    3'b001:  o_cmp_op = bne;
                    3'b100:  o_cmp_op = blt;
                    3'b101:  o_cmp_op = bge;
                    3'b110:  o_cmp_op = bltu;
                    3'b111:  o_cmp_op = bgeu;
                    default: o_cmp_op = beq;
                endcase
            end
            op_load: begin
                o_mem_read = 1'b1;
                o_ld_reg   = 1'b1;
                case (funct3)
                    3'b000:  o_wb_src = wb_lb;
                    3'b001:  o_wb_src = wb_lh;
                    3'b100:  o_wb_src = wb_lbu;
                    3'b101:  o_wb_src = wb_lhu;
                    default: o_wb_src = wb_lw;
                endcase
            end
            op_store: begin
                o_alu_src2  = src2_s_imm;
                o_mem_write = 1'b1;
            end
            op_imm, op_reg: begin
                o_ld_reg = 1'b1;
                if (o_opcode == op_reg) begin
                    o_alu_src2 = src2_rs2;
                end else begin
                    o_cmp_src = cmp_i_imm;
                end
                case (funct3)
                    // sub exists only in the register form
                    3'b000:  o_alu_op = (o_opcode == op_reg && funct7_b5) ? alu_sub : alu_add;
                    3'b001:  o_alu_op = alu_sll;
                    // slt and sltu come from the comparator
                    3'b010: begin
                        o_cmp_op = blt;
                        o_wb_src = wb_br_en;
                    end
                    3'b011: begin
                        o_cmp_op = bltu;
                        o_wb_src = wb_br_en;
                    end
                    3'b100:  o_alu_op = alu_xor;
                    3'b101:  o_alu_op = funct7_b5 ? alu_sra : alu_srl;
                    3'b110:  o_alu_op = alu_or;
                    default: o_alu_op = alu_and;
                endcase
            end
            default: ;
        endcase
    end

endmodule

/* pipe_ctrl_pkg.sv */
// rv32i pipeline control definitions
package pipe_ctrl_pkg;

    // stages behind fetch: de, exe, mem, wb
    localparam int NUM_STAGES = 4;
    localparam int REG_ADDR_W = 5;
    localparam int INSTR_W    = 32;

    // rv32i major opcodes, bits [6:0] of the word
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // alu ops, mostly lined up with arith funct3
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_t;

    // comparator ops, same codes as branch funct3
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic {
        src1_rs1,
        src1_pc
    } alu_src1_t;

    typedef enum logic [2:0] {
        src2_rs2,
        src2_i_imm,
        src2_u_imm,
        src2_b_imm,
        src2_s_imm,
        src2_j_imm
    } alu_src2_t;

    typedef enum logic {
        cmp_rs2,
        cmp_i_imm
    } cmp_src_t;

    // regfile write data select
    typedef enum logic [3:0] {
        wb_alu,
        wb_br_en,
        wb_u_imm,
        wb_pc_plus4,
        wb_lb,
        wb_lh,
        wb_lw,
        wb_lbu,
        wb_lhu
    } wb_src_t;

    typedef enum logic [1:0] {
        pc_plus4,
        pc_alu,
        pc_alu_mod2
    } pc_src_t;

endpackage

/* pipe_ctrl_top.sv */
// rv32i pipeline control top
`timescale 1ns/100ps

module pipe_ctrl_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [pipe_ctrl_pkg::INSTR_W-1:0]    i_instr,
    input  logic                                 i_fetch_rdy,
    input  logic                                 i_de_rdy,
    input  logic                                 i_exe_rdy,
    input  logic                                 i_mem_rdy,
    input  logic                                 i_wb_rdy,
    input  logic                                 i_br_en,
    output logic                                 o_load_pc,
    output logic                                 o_imem_read,
    output logic                                 o_if_de_ld,
    output logic                                 o_de_exe_ld,
    output logic                                 o_exe_mem_ld,
    output logic                                 o_mem_wb_ld,
    output logic                                 o_de_valid,
    output logic                                 o_exe_valid,
    output logic                                 o_mem_valid,
    output logic                                 o_wb_valid,
    output pipe_ctrl_pkg::alu_op_t               o_alu_op,
    output pipe_ctrl_pkg::alu_src1_t             o_alu_src1,
    output pipe_ctrl_pkg::alu_src2_t             o_alu_src2,
    output pipe_ctrl_pkg::cmp_op_t               o_cmp_op,
    output pipe_ctrl_pkg::cmp_src_t              o_cmp_src,
    output pipe_ctrl_pkg::pc_src_t               o_pc_src,
    output logic                                 o_mem_read,
    output logic                                 o_mem_write,
    output logic                                 o_ld_reg,
    output pipe_ctrl_pkg::wb_src_t               o_wb_src,
    output logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] o_rd
);
    import pipe_ctrl_pkg::*;

    // decoder outputs into the decode register
    alu_op_t               dec_alu_op;
    alu_src1_t             dec_alu_src1;
    alu_src2_t             dec_alu_src2;
    cmp_op_t               dec_cmp_op;
    cmp_src_t              dec_cmp_src;
    logic                  dec_mem_read;
    logic                  dec_mem_write;
    logic                  dec_ld_reg;
    wb_src_t               dec_wb_src;
    logic [REG_ADDR_W-1:0] dec_rd;
    opcode_t               dec_opcode;

    // bit 0 de up to bit 3 wb
    logic [NUM_STAGES-1:0] stage_rdy;
    logic [NUM_STAGES-1:0] stage_ld;
    logic [NUM_STAGES-1:0] stage_valid;

    assign stage_rdy = {i_wb_rdy, i_mem_rdy, i_exe_rdy, i_de_rdy};

    assign o_if_de_ld   = stage_ld[0];
    assign o_de_exe_ld  = stage_ld[1];
    assign o_exe_mem_ld = stage_ld[2];
    assign o_mem_wb_ld  = stage_ld[3];
    assign o_de_valid   = stage_valid[0];
    assign o_exe_valid  = stage_valid[1];
    assign o_mem_valid  = stage_valid[2];
    assign o_wb_valid   = stage_valid[3];

    instr_decoder u_decoder (
        .i_instr     (i_instr),
        .o_alu_op    (dec_alu_op),
        .o_alu_src1  (dec_alu_src1),
        .o_alu_src2  (dec_alu_src2),
        .o_cmp_op    (dec_cmp_op),
        .o_cmp_src   (dec_cmp_src),
        .o_mem_read  (dec_mem_read),
        .o_mem_write (dec_mem_write),
        .o_ld_reg    (dec_ld_reg),
        .o_wb_src    (dec_wb_src),
        .o_rd        (dec_rd),
        .o_opcode    (dec_opcode)
    );

    stall_ctrl #(
        .NUM_STAGES (NUM_STAGES)
    ) u_stall (
        .clk           (clk),
        .rst           (rst),
        .i_stage_rdy   (stage_rdy),
        .i_stage_valid (stage_valid),
        .o_stage_ld    (stage_ld),
        .o_imem_read   (o_imem_read),
        .o_load_pc     (o_load_pc)
    );

    cw_pipe u_pipe (
        .clk           (clk),
        .rst           (rst),
        .i_fetch_rdy   (i_fetch_rdy),
        .i_br_en       (i_br_en),
        .i_stage_ld    (stage_ld),
        .i_stage_rdy   (stage_rdy),
        .i_alu_op      (dec_alu_op),
        .i_alu_src1    (dec_alu_src1),
        .i_alu_src2    (dec_alu_src2),
        .i_cmp_op      (dec_cmp_op),
        .i_cmp_src     (dec_cmp_src),
        .i_mem_read    (dec_mem_read),
        .i_mem_write   (dec_mem_write),
        .i_ld_reg      (dec_ld_reg),
        .i_wb_src      (dec_wb_src),
        .i_rd          (dec_rd),
        .i_opcode      (dec_opcode),
        .o_stage_valid (stage_valid),
        .o_alu_op      (o_alu_op),
        .o_alu_src1    (o_alu_src1),
        .o_alu_src2    (o_alu_src2),
        .o_cmp_op      (o_cmp_op),
        .o_cmp_src     (o_cmp_src),
        .o_pc_src      (o_pc_src),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_ld_reg      (o_ld_reg),
        .o_wb_src      (o_wb_src),
        .o_rd          (o_rd)
    );

endmodule

/* stall_ctrl.sv */
// pipeline stall and load control
`timescale 1ns/100ps

module stall_ctrl #(
    parameter int NUM_STAGES = pipe_ctrl_pkg::NUM_STAGES
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [NUM_STAGES-1:0] i_stage_rdy,
    input  logic [NUM_STAGES-1:0] i_stage_valid,
    output logic [NUM_STAGES-1:0] o_stage_ld,
    output logic                  o_imem_read,
    output logic                  o_load_pc
);
    // stage holds a live word that is not finished
    logic [NUM_STAGES-1:0] stall;
    // bit k set when any stage from k to the end stalls
    logic [NUM_STAGES-1:0] stall_from;

    assign stall = i_stage_valid & ~i_stage_rdy;

    // or the stalls together from wb back toward de
    always_comb begin
        stall_from[NUM_STAGES-1] = stall[NUM_STAGES-1];
        for (int k = NUM_STAGES - 2; k >= 0; k--) begin
            stall_from[k] = stall_from[k+1] | stall[k];
        end
    end

    always_comb begin
        if (rst) begin
            o_stage_ld  = '0;
            o_imem_read = 1'b0;
            o_load_pc   = 1'b0;
        end else begin
            o_stage_ld  = ~stall_from;
            // fetch advances together with the if/de register
            o_imem_read = ~stall_from[0];
            o_load_pc   = ~stall_from[0];
        end
    end

endmodule

/* tb_pipe_ctrl_vectors.svh */
// decode vector table
`ifndef TB_PIPE_CTRL_VECTORS_SVH
`define TB_PIPE_CTRL_VECTORS_SVH

localparam int NUM_VECTORS = 18;

// columns: instr, br_en, alu_op, alu_src1, alu_src2, cmp_op, cmp_src,
//          pc_src, mem_read, mem_write, ld_reg, wb_src, rd
task automatic fill_vectors();
    // upper immediate and jumps
    add_row(32'h123450b7, 1'b0, alu_add, src1_rs1, src2_i_imm, beq, cmp_rs2,
            pc_plus4, 1'b0, 1'b0, 1'b1, wb_u_imm, 5'd1);
    add_row(32'h00001117, 1'b0, alu_add, src1_pc, src2_u_imm, beq, cmp_rs2,
            pc_plus4, 1'b0, 1'b0, 1'b1, wb_alu, 5'd2);
    add_row(32'h008001ef, 1'b0, alu_add, src1_pc, src2_j_imm, beq, cmp_rs2,
            pc_alu, 1'b0, 1'b0, 1'b1, wb_pc_plus4, 5'd3);
    add_row(32'h00008267, 1'b0, alu_add, src1_rs1, src2_i_imm, beq, cmp_rs2,
            pc_alu_mod2, 1'b0, 1'b0, 1'b1, wb_pc_plus4, 5'd4);
    // branches, rd column is imm[4:1|11] of the word
    add_row(32'h00208463, 1'b1, alu_add, src1_pc, src2_b_imm, beq, cmp_rs2,
            pc_alu, 1'b0, 1'b0, 1'b0, wb_alu, 5'd8);
    add_row(32'h00209463, 1'b0, alu_add, src1_pc, src2_b_imm, bne, cmp_rs2,
            pc_plus4, 1'b0, 1'b0, 1'b0, wb_alu, 5'd8);
    add_row(32'h0020e463, 1'b1, alu_add, src1_pc, src2_b_imm, bltu, cmp_rs2,
            pc_alu, 1'b0, 1'b0, 1'b0, wb_alu, 5'd8);
    add_row(32'h0020d463, 1'b0, alu_add, src1_pc, src2_b_imm, bge, cmp_rs2,
            pc_plus4, 1'b0, 1'b0, 1'b0, wb_alu, 5'd8);
    // loads and a store
    add_row(32'h0040a283, 1'b0, alu_add, src1_rs1, src2_i_imm, beq, cmp_rs2,
            pc_plus4, 1'b1, 1'b0, 1'b1, wb_lw, 5'd5);
    add_row(32'h0000c303, 1'b0, alu_add, src1_rs1, src2_i_imm, beq, cmp_rs2,
            pc_plus4, 1'b1, 1'b0, 1'b1, wb_lbu, 5'd6);
    add_row(32'h00009383, 1'b0, alu_add, src1_rs1, src2_i_imm, beq, cmp_rs2,
            pc_plus4, 1'b1, 1'b0, 1'b1, wb_lh, 5'd7);
    add_row(32'h0020a423, 1'b0, alu_add, src1_rs1, src2_s_imm, beq, cmp_rs2,
            pc_plus4, 1'b0, 1'b1, 1'b0, wb_alu, 5'd8);
    // immediate and register arithmetic
    add_row(32'h00108413, 1'b0, alu_add, src1_rs1, src2_i_imm, beq, cmp_i_imm,
            pc_plus4, 1'b0, 1'b0, 1'b1, wb_alu, 5'd8);
    add_row(32'h0050a493, 1'b0, alu_add, src1_rs1, src2_i_imm, blt, cmp_i_imm,
            pc_plus4, 1'b0, 1'b0, 1'b1, wb_br_en, 5'd9);
    add_row(32'h4030d513, 1'b0, alu_sra, src1_rs1, src2_i_imm, beq, cmp_i_imm,
            pc_plus4, 1'b0, 1'b0, 1'b1, wb_alu, 5'd10);
    add_row(32'h402085b3, 1'b0, alu_sub, src1_rs1, src2_rs2, beq, cmp_rs2,
            pc_plus4, 1'b0, 1'b0, 1'b1, wb_alu, 5'd11);
    add_row(32'h0020b6b3, 1'b0, alu_add, src1_rs1, src2_rs2, bltu, cmp_rs2,
            pc_plus4, 1'b0, 1'b0, 1'b1, wb_br_en, 5'd13);
    // imm bit 30 set, still xor
    add_row(32'hfff0c793, 1'b0, alu_xor, src1_rs1, src2_i_imm, beq, cmp_i_imm,
            pc_plus4, 1'b0, 1'b0, 1'b1, wb_alu, 5'd15);
endtask

`endif

/* tb_pipe_ctrl.sv */
// pipeline control testbench
`timescale 1ns/100ps

module tb_pipe_ctrl;
    import pipe_ctrl_pkg::*;

    `include "tb_pipe_ctrl_vectors.svh"

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_SCENARIOS   = 2;
    localparam int WATCHDOG_CYCLES = (NUM_VECTORS + NUM_SCENARIOS) * 10;
    localparam int WAIT_LIMIT      = 20;
    localparam logic [31:0] SEED   = 32'h62e7_8db5;

    // words reused by the scenarios
    localparam logic [INSTR_W-1:0] ADDI_WORD = 32'h00108413;
    localparam logic [INSTR_W-1:0] LW_WORD   = 32'h0040a283;
    localparam logic [INSTR_W-1:0] JAL_WORD  = 32'h008001ef;

    typedef struct packed {
        logic [INSTR_W-1:0]    instr;
        logic                  br_en;
        alu_op_t               alu_op;
        alu_src1_t             alu_src1;
        alu_src2_t             alu_src2;
        cmp_op_t               cmp_op;
        cmp_src_t              cmp_src;
        pc_src_t               pc_src;
        logic                  mem_read;
        logic                  mem_write;
        logic                  ld_reg;
        wb_src_t               wb_src;
        logic [REG_ADDR_W-1:0] rd;
    } vector_t;

    vector_t     vectors [NUM_VECTORS];
    int          row_count;
    int unsigned seed_state;

    logic                  clk, rst;
    logic [INSTR_W-1:0]    i_instr;
    logic                  i_fetch_rdy, i_de_rdy, i_exe_rdy, i_mem_rdy, i_wb_rdy, i_br_en;
    logic                  o_load_pc, o_imem_read;
    logic                  o_if_de_ld, o_de_exe_ld, o_exe_mem_ld, o_mem_wb_ld;
    logic                  o_de_valid, o_exe_valid, o_mem_valid, o_wb_valid;
    alu_op_t               o_alu_op;
    alu_src1_t             o_alu_src1;
    alu_src2_t             o_alu_src2;
    cmp_op_t               o_cmp_op;
    cmp_src_t              o_cmp_src;
    pc_src_t               o_pc_src;
    logic                  o_mem_read, o_mem_write, o_ld_reg;
    wb_src_t               o_wb_src;
    logic [REG_ADDR_W-1:0] o_rd;

    // bit 0 de up to bit 3 wb
    logic [NUM_STAGES-1:0] valid_now;
    assign valid_now = {o_wb_valid, o_mem_valid, o_exe_valid, o_de_valid};

    pipe_ctrl_top dut0 (.*);

    task automatic add_row(
        input logic [INSTR_W-1:0]    instr,
        input logic                  br_en,
        input alu_op_t               alu_op,
        input alu_src1_t             alu_src1,
        input alu_src2_t             alu_src2,
        input cmp_op_t               cmp_op,
        input cmp_src_t              cmp_src,
        input pc_src_t               pc_src,
        input logic                  mem_read,
        input logic                  mem_write,
        input logic                  ld_reg,
        input wb_src_t               wb_src,
        input logic [REG_ADDR_W-1:0] rd
    );
        vectors[row_count] = '{instr, br_en, alu_op, alu_src1, alu_src2, cmp_op, cmp_src,
                               pc_src, mem_read, mem_write, ld_reg, wb_src, rd};
        row_count++;
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    task automatic check_rd(input string what, input logic [REG_ADDR_W-1:0] got,
                            input logic [REG_ADDR_W-1:0] exp);
        if (got !== exp) begin
            report_error($sformatf("%s got %0d expected %0d", what, got, exp));
        end
    endtask

    task automatic check_alu_op(input string what, input alu_op_t got, input alu_op_t exp);
        if (got !== exp) begin
            report_error($sformatf("%s got %s expected %s", what, got.name(), exp.name()));
        end
    endtask

    task automatic check_alu_src1(input string what, input alu_src1_t got,
                                  input alu_src1_t exp);
        if (got !== exp) begin
            report_error($sformatf("%s got %s expected %s", what, got.name(), exp.name()));
        end
    endtask

    task automatic check_alu_src2(input string what, input alu_src2_t got,
                                  input alu_src2_t exp);
        if (got !== exp) begin
            report_error($sformatf("%s got %s expected %s", what, got.name(), exp.name()));
        end
    endtask

    task automatic check_cmp_op(input string what, input cmp_op_t got, input cmp_op_t exp);
        if (got !== exp) begin
            report_error($sformatf("%s got %s expected %s", what, got.name(), exp.name()));
        end
    endtask

    task automatic check_cmp_src(input string what, input cmp_src_t got, input cmp_src_t exp);
        if (got !== exp) begin
            report_error($sformatf("%s got %s expected %s", what, got.name(), exp.name()));
        end
    endtask

    task automatic check_pc_src(input string what, input pc_src_t got, input pc_src_t exp);
        if (got !== exp) begin
            report_error($sformatf("%s got %s expected %s", what, got.name(), exp.name()));
        end
    endtask

    task automatic check_wb_src(input string what, input wb_src_t got, input wb_src_t exp);
        if (got !== exp) begin
            report_error($sformatf("%s got %s expected %s", what, got.name(), exp.name()));
        end
    endtask

    // all four loads plus fetch controls
    task automatic check_loads(input logic [3:0] exp_ld, input logic exp_fetch);
        check_bit("if_de_ld", o_if_de_ld, exp_ld[0]);
        check_bit("de_exe_ld", o_de_exe_ld, exp_ld[1]);
        check_bit("exe_mem_ld", o_exe_mem_ld, exp_ld[2]);
        check_bit("mem_wb_ld", o_mem_wb_ld, exp_ld[3]);
        check_bit("imem_read", o_imem_read, exp_fetch);
        check_bit("load_pc", o_load_pc, exp_fetch);
    endtask

    task automatic check_exe_row(input int j);
        string tag;
        tag = $sformatf("row %0d", j);
        check_bit({tag, " exe_valid"}, o_exe_valid, 1'b1);
        check_alu_op({tag, " alu_op"}, o_alu_op, vectors[j].alu_op);
        check_alu_src1({tag, " alu_src1"}, o_alu_src1, vectors[j].alu_src1);
        check_alu_src2({tag, " alu_src2"}, o_alu_src2, vectors[j].alu_src2);
        check_cmp_op({tag, " cmp_op"}, o_cmp_op, vectors[j].cmp_op);
        check_cmp_src({tag, " cmp_src"}, o_cmp_src, vectors[j].cmp_src);
        check_pc_src({tag, " pc_src"}, o_pc_src, vectors[j].pc_src);
    endtask

    task automatic check_mem_row(input int j);
        string tag;
        tag = $sformatf("row %0d", j);
        check_bit({tag, " mem_valid"}, o_mem_valid, 1'b1);
        check_bit({tag, " mem_read"}, o_mem_read, vectors[j].mem_read);
        check_bit({tag, " mem_write"}, o_mem_write, vectors[j].mem_write);
    endtask

    task automatic check_wb_row(input int j);
        string tag;
        tag = $sformatf("row %0d", j);
        check_bit({tag, " wb_valid"}, o_wb_valid, 1'b1);
        check_bit({tag, " ld_reg"}, o_ld_reg, vectors[j].ld_reg);
        check_wb_src({tag, " wb_src"}, o_wb_src, vectors[j].wb_src);
        check_rd({tag, " rd"}, o_rd, vectors[j].rd);
    endtask

    // returns on the first falling edge where the stage is valid
    task automatic wait_stage_valid(input int stage, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (valid_now[stage] !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                report_error($sformatf("%s never showed up", what));
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    // mem_rdy drops on the edge that moves the load into memory
    task automatic run_mem_stall();
        int hold;
        hold = $urandom_range(4, 1);
        @(posedge clk);
        i_instr     <= ADDI_WORD;
        i_fetch_rdy <= 1'b1;
        @(posedge clk);
        i_instr <= LW_WORD;
        @(posedge clk);
        i_fetch_rdy <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        i_mem_rdy <= 1'b0;
        @(negedge clk);
        // addi drained into wb, lw held in mem
        check_bit("stall wb_valid", o_wb_valid, 1'b1);
        check_bit("stall ld_reg", o_ld_reg, 1'b1);
        check_loads(4'b1000, 1'b0);
        repeat (hold) begin
            @(posedge clk);
            @(negedge clk);
            check_bit("bubble wb_valid", o_wb_valid, 1'b0);
            check_bit("bubble ld_reg", o_ld_reg, 1'b0);
            check_bit("held mem_valid", o_mem_valid, 1'b1);
            check_bit("held mem_read", o_mem_read, 1'b1);
            check_bit("held mem_write", o_mem_write, 1'b0);
            check_loads(4'b1000, 1'b0);
        end
        @(posedge clk);
        i_mem_rdy <= 1'b1;
        wait_stage_valid(3, "released load in wb");
        check_bit("released ld_reg", o_ld_reg, 1'b1);
        check_wb_src("released wb_src", o_wb_src, wb_lw);
        check_rd("released rd", o_rd, 5'd5);
    endtask

    // one missing fetch between two jal words
    task automatic run_fetch_bubble();
        @(posedge clk);
        i_instr     <= JAL_WORD;
        i_fetch_rdy <= 1'b1;
        @(posedge clk);
        i_fetch_rdy <= 1'b0;
        @(posedge clk);
        i_fetch_rdy <= 1'b1;
        @(negedge clk);
        check_bit("gap de_valid", o_de_valid, 1'b0);
        check_bit("first jal exe_valid", o_exe_valid, 1'b1);
        check_pc_src("first jal pc_src", o_pc_src, pc_alu);
        @(posedge clk);
        i_fetch_rdy <= 1'b0;
        @(negedge clk);
        // stale jal opcode sits in exe but is not valid
        check_bit("bubble exe_valid", o_exe_valid, 1'b0);
        check_pc_src("bubble pc_src", o_pc_src, pc_plus4);
        @(posedge clk);
        @(negedge clk);
        check_bit("second jal exe_valid", o_exe_valid, 1'b1);
        check_pc_src("second jal pc_src", o_pc_src, pc_alu);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog timeout, the tests did not finish in time");
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst         = 1'b1;
        i_instr     = '0;
        i_fetch_rdy = 1'b0;
        i_de_rdy    = 1'b1;
        i_exe_rdy   = 1'b1;
        i_mem_rdy   = 1'b1;
        i_wb_rdy    = 1'b1;
        i_br_en     = 1'b0;
        row_count   = 0;
        seed_state  = $urandom(SEED);
        fill_vectors();

        // everything frozen while reset is high
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_loads(4'b0000, 1'b0);
        @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_bit("idle de_valid", o_de_valid, 1'b0);
        check_bit("idle exe_valid", o_exe_valid, 1'b0);
        check_bit("idle mem_valid", o_mem_valid, 1'b0);
        check_bit("idle wb_valid", o_wb_valid, 1'b0);
        check_bit("idle mem_read", o_mem_read, 1'b0);
        check_bit("idle mem_write", o_mem_write, 1'b0);
        check_bit("idle ld_reg", o_ld_reg, 1'b0);
        check_pc_src("idle pc_src", o_pc_src, pc_plus4);

        // row k enters on edge k, br_en tracks the row in exe
        for (int k = 0; k < NUM_VECTORS + 4; k++) begin
            @(posedge clk);
            if (k < NUM_VECTORS) begin
                i_instr     <= vectors[k].instr;
                i_fetch_rdy <= 1'b1;
            end else begin
                i_fetch_rdy <= 1'b0;
            end
            if (k >= 2 && k < NUM_VECTORS + 2) begin
                i_br_en <= vectors[k - 2].br_en;
            end else begin
                i_br_en <= 1'b0;
            end
            @(negedge clk);
            check_loads(4'b1111, 1'b1);
            if (k >= 2 && k - 2 < NUM_VECTORS) begin
                check_exe_row(k - 2);
            end
            if (k >= 3 && k - 3 < NUM_VECTORS) begin
                check_mem_row(k - 3);
            end
            if (k >= 4) begin
                check_wb_row(k - 4);
            end
        end

        run_mem_stall();
        run_fetch_bubble();

        $display("Result: PASSED");
        $finish;
    end

endmodule
